/* list.f */
+incdir+verilog
verilog/cdi_pkg.sv
verilog/sdram_boot_arbiter.sv
verilog/worm_byte_splitter.sv
verilog/nvram_sync_fsm.sv
verilog/cdi_host_bridge.sv
tests/cdi_host_bridge_sva.sv
tests/cdi_host_bridge_tb.sv

/* tests/cdi_host_bridge_sva.sv */
`timescale 1ns/10ps

module cdi_host_bridge_sva
    import cdi_pkg::*;
(
    input logic         clk_sys,
    input logic         cditop_reset,
    input logic         core_hold,
    input logic         sdram_busy,
    input sdram_req_t   sdram_req,
    input logic         nvram_hps_rd,
    input logic         nvram_hps_wr,
    input nvram_state_e state,
    input logic         nvram_allow_cpu_access
);

    // Bridge owns the SDRAM port while the core is held
    property no_access_while_busy;
        @(posedge clk_sys) disable iff (cditop_reset)
            (core_hold && sdram_busy) |-> !(sdram_req.rd || sdram_req.wr);
    endproperty

    property single_host_request;
        @(posedge clk_sys) disable iff (cditop_reset)
            !(nvram_hps_rd && nvram_hps_wr);
    endproperty

    property no_cpu_access_in_transfer;
        @(posedge clk_sys) disable iff (cditop_reset)
            (state != NVRAM_IDLE) |-> !nvram_allow_cpu_access;
    endproperty

    assert property (no_access_while_busy)
        else $error("SDRAM access presented while the controller is busy");
    assert property (single_host_request)
        else $error("Host read and write requests are high together");
    assert property (no_cpu_access_in_transfer)
        else $error("CPU access to NvRAM allowed during a transfer");

endmodule

// ==========================================================================
// Attachment to the arbiter and the NvRAM state machine
// ==========================================================================

bind sdram_boot_arbiter cdi_host_bridge_sva arbiter_sva (
    .clk_sys                (clk_sys),
    .cditop_reset           (cditop_reset),
    .core_hold              (core_hold),
    .sdram_busy             (sdram_busy),
    .sdram_req              (sdram_req),
    .nvram_hps_rd           (1'b0),
    .nvram_hps_wr           (1'b0),
    .state                  (NVRAM_IDLE),
    .nvram_allow_cpu_access (1'b0)
);

bind nvram_sync_fsm cdi_host_bridge_sva fsm_sva (
    .clk_sys                (clk_sys),
    .cditop_reset           (cditop_reset),
    .core_hold              (1'b0),
    .sdram_busy             (1'b0),
    .sdram_req              ('0),
    .nvram_hps_rd           (nvram_hps_rd),
    .nvram_hps_wr           (nvram_hps_wr),
    .state                  (state),
    .nvram_allow_cpu_access (nvram_allow_cpu_access)
);

/* tests/cdi_host_bridge_tb.sv */
`timescale 1ns/10ps

`include "cdi_consts.svh"

module cdi_host_bridge_tb
    import cdi_pkg::*;
();

    localparam int CYCLE_LIMIT = 4000;

    logic        clk_sys;
    logic        cditop_reset;
    logic        osd_reset_req;
    logic        reset_on_nvram_mount;
    logic        ioctl_download;
    ioctl_beat_t ioctl;
    sdram_req_t  core_sdram_req;
    logic        sdram_busy;
    logic        nvram_media_change;
    img_size_t   img_size;
    logic        osd_status;
    logic        nvram_cpu_changed;
    byte_t       nvram_backup_data;
    logic        nvram_hps_ack;
    sd_buff_t    sd_buff;
    sdram_req_t  sdram_req;
    logic        core_hold;
    logic        download_overflow;
    worm_wr_t    worm_wr;
    nvram_port_t nvram_port;
    logic        nvram_allow_cpu_access;
    logic        nvram_hps_rd;
    logic        nvram_hps_wr;
    sdram_word_t nvram_hps_din;
    logic        led_user;

    int          errors = 0;
    int          cycle_count = 0;
    int          busy_left = 0;
    int unsigned seed_value;
    byte_t       nvram_mem [0:8191];
    sdram_word_t restore_words [$];

    cdi_host_bridge UUT (.*);

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    // ======================================================================
    // Models of the SDRAM controller and the core NvRAM
    // ======================================================================

    // Every accepted access keeps the controller busy for 3 cycles
    always @(posedge clk_sys) begin
        if (cditop_reset) begin
            sdram_busy <= 1'b0;
            busy_left  <= 0;
        end else if (busy_left != 0) begin
            busy_left <= busy_left - 1;
            if (busy_left == 1) begin
                sdram_busy <= 1'b0;
            end
        end else if (!sdram_busy && (sdram_req.rd || sdram_req.wr)) begin
            sdram_busy <= 1'b1;
            busy_left  <= 3;
        end
    end

    // One cycle read latency
    always @(posedge clk_sys) begin
        if (nvram_port.write) begin
            nvram_mem[nvram_port.adr] <= nvram_port.data;
        end
        nvram_backup_data <= nvram_mem[nvram_port.adr];
    end

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic byte_t fill_byte(input int adr);
        nvram_adr_t a;
        a = nvram_adr_t'(adr);
        return a[7:0] ^ {a[12:8], a[2:0]};
    endfunction

    // Restored words sit at the bottom with the fill pattern above them
    function automatic byte_t expected_nvram_byte(input int adr);
        int k;
        k = adr / 2;
        if (k < restore_words.size()) begin
            if (adr % 2 == 1) begin
                return restore_words[k][15:8];
            end
            return restore_words[k][7:0];
        end
        return fill_byte(adr);
    endfunction

    task automatic check_value(input string test_name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            errors = errors + 1;
            $display("error %s: expected %0h, actual %0h", test_name, expected, actual);
            $display("test failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================

    task automatic reset_and_hold_test();
        logic [63:0] rnd;
        @(negedge clk_sys);
        check_value("reset_and_hold", 1, core_hold);
        check_value("reset_and_hold", 0, nvram_hps_rd);
        check_value("reset_and_hold", 0, nvram_hps_wr);
        check_value("reset_and_hold", 0, nvram_port.write);
        check_value("reset_and_hold", 0, led_user);
        check_value("reset_and_hold", 1, nvram_allow_cpu_access);
        check_value("reset_and_hold", 0, download_overflow);
        check_value("reset_and_hold", 0, worm_wr.wr);
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_value("reset_and_hold", 0, core_hold);
        // OSD reset first and then the download flag
        for (int src = 0; src < 2; src++) begin
            @(posedge clk_sys);
            if (src == 0) begin
                osd_reset_req <= 1'b1;
            end else begin
                ioctl_download <= 1'b1;
            end
            @(negedge clk_sys);
            check_value("reset_and_hold", 0, core_hold);
            @(posedge clk_sys);
            osd_reset_req  <= 1'b0;
            ioctl_download <= 1'b0;
            @(negedge clk_sys);
            check_value("reset_and_hold", 1, core_hold);
            @(posedge clk_sys);
            @(negedge clk_sys);
            check_value("reset_and_hold", 0, core_hold);
        end
        repeat (8) begin
            @(posedge clk_sys);
            rnd = {$urandom, $urandom};
            core_sdram_req <= rnd[45:0];
            @(negedge clk_sys);
            check_value("reset_and_hold", core_sdram_req, sdram_req);
        end
        @(posedge clk_sys);
        core_sdram_req <= '0;
    endtask

    task automatic rom_download_test();
        ioctl_beat_t beat;
        @(posedge clk_sys);
        ioctl_download <= 1'b1;
        @(negedge clk_sys);
        while (!core_hold) @(negedge clk_sys);
        for (int i = 0; i < 7; i++) begin
            @(posedge clk_sys);
            beat       = '0;
            beat.wr    = 1'b1;
            beat.addr  = $urandom;
            beat.index = $urandom;
            beat.index[`CDI_WORM_INDEX_BIT] = 1'b0;
            beat.data  = $urandom;
            ioctl <= beat;
            @(posedge clk_sys);
            // Last beat lands while the word is still in flight
            if (i == 6) begin
                beat.data = $urandom;
                ioctl <= beat;
                @(posedge clk_sys);
                ioctl <= '0;
                @(negedge clk_sys);
                check_value("rom_download", 1, download_overflow);
                while (!sdram_req.rd) @(negedge clk_sys);
            end else begin
                ioctl <= '0;
                @(negedge clk_sys);
                while (!sdram_req.wr) @(negedge clk_sys);
                check_value("rom_download", {`CDI_ROM_REGION_SEL, beat.addr[21:1], 1'b0},
                            sdram_req.addr);
                check_value("rom_download", {beat.data[7:0], beat.data[15:8]}, sdram_req.din);
                check_value("rom_download", 1, sdram_req.word);
                check_value("rom_download", 0, sdram_req.burst);
                check_value("rom_download", 0, download_overflow);
                while (!sdram_busy) @(negedge clk_sys);
                while (sdram_busy) @(negedge clk_sys);
                // No second write for the same word
                check_value("rom_download", 0, sdram_req.wr);
                repeat (2) @(posedge clk_sys);
            end
        end
    endtask

    task automatic refresh_test();
        repeat (5) begin
            @(negedge clk_sys);
            while (sdram_busy) @(negedge clk_sys);
            check_value("refresh", 1, sdram_req.rd);
            check_value("refresh", 1, sdram_req.refresh);
            check_value("refresh", 0, sdram_req.wr);
            check_value("refresh", 1, sdram_req.word);
            @(posedge clk_sys);
        end
        ioctl_download <= 1'b0;
        @(negedge clk_sys);
        while (core_hold) @(negedge clk_sys);
    endtask

    task automatic worm_test();
        ioctl_beat_t beat;
        repeat (4) begin
            @(posedge clk_sys);
            beat         = '0;
            beat.wr      = 1'b1;
            beat.addr    = $urandom;
            beat.addr[0] = 1'b0;
            beat.index   = $urandom;
            beat.index[`CDI_WORM_INDEX_BIT] = 1'b1;
            beat.data    = $urandom;
            ioctl <= beat;
            @(posedge clk_sys);
            ioctl <= '0;
            @(negedge clk_sys);
            check_value("worm", 1, worm_wr.wr);
            check_value("worm", beat.addr[12:0], worm_wr.adr);
            check_value("worm", beat.data[7:0], worm_wr.data);
            @(posedge clk_sys);
            @(negedge clk_sys);
            check_value("worm", 1, worm_wr.wr);
            check_value("worm", {beat.addr[12:1], 1'b1}, worm_wr.adr);
            check_value("worm", beat.data[15:8], worm_wr.data);
            @(posedge clk_sys);
            @(negedge clk_sys);
            check_value("worm", 0, worm_wr.wr);
        end
    endtask

    task automatic restore_test();
        sdram_word_t word;
        @(posedge clk_sys);
        nvram_media_change   <= 1'b1;
        reset_on_nvram_mount <= 1'b1;
        img_size             <= {$urandom, $urandom} | 64'd1;
        @(posedge clk_sys);
        nvram_media_change   <= 1'b0;
        reset_on_nvram_mount <= 1'b0;
        @(negedge clk_sys);
        check_value("restore", 1, core_hold);
        while (!nvram_hps_rd) @(negedge clk_sys);
        check_value("restore", 0, nvram_allow_cpu_access);
        @(posedge clk_sys);
        nvram_hps_ack <= 1'b1;
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_value("restore", 0, nvram_hps_rd);
        restore_words.delete();
        for (int k = 0; k < 4; k++) begin
            word = $urandom;
            restore_words.push_back(word);
            @(posedge clk_sys);
            sd_buff.addr <= sd_buff_addr_t'(k);
            sd_buff.data <= word;
            sd_buff.wr   <= 1'b1;
            @(posedge clk_sys);
            sd_buff.wr <= 1'b0;
            @(negedge clk_sys);
            check_value("restore", 1, nvram_port.write);
            check_value("restore", 2 * k, nvram_port.adr);
            check_value("restore", word[7:0], nvram_port.data);
            @(posedge clk_sys);
            @(negedge clk_sys);
            check_value("restore", 1, nvram_port.write);
            check_value("restore", 2 * k + 1, nvram_port.adr);
            check_value("restore", word[15:8], nvram_port.data);
            @(posedge clk_sys);
            @(negedge clk_sys);
            check_value("restore", 0, nvram_port.write);
        end
        check_value("restore", 0, nvram_allow_cpu_access);
        @(posedge clk_sys);
        nvram_hps_ack <= 1'b0;
        sd_buff       <= '0;
        @(negedge clk_sys);
        while (!nvram_allow_cpu_access) @(negedge clk_sys);
    endtask

    task automatic backup_test();
        sdram_word_t expected;
        @(posedge clk_sys);
        nvram_cpu_changed <= 1'b1;
        @(posedge clk_sys);
        nvram_cpu_changed <= 1'b0;
        @(negedge clk_sys);
        check_value("backup", 1, led_user);
        @(posedge clk_sys);
        osd_status <= 1'b1;
        @(negedge clk_sys);
        while (!nvram_hps_wr) @(negedge clk_sys);
        check_value("backup", 0, led_user);
        check_value("backup", 0, nvram_allow_cpu_access);
        @(posedge clk_sys);
        nvram_hps_ack <= 1'b1;
        // Two words past the restored area read the fill pattern
        for (int n = 0; n < 6; n++) begin
            if (n != 0) begin
                @(posedge clk_sys);
                sd_buff.addr <= sd_buff_addr_t'(n);
            end
            repeat (5) @(posedge clk_sys);
            @(negedge clk_sys);
            check_value("backup", 0, nvram_hps_wr);
            expected = {expected_nvram_byte(2 * n + 1), expected_nvram_byte(2 * n)};
            check_value("backup", expected, nvram_hps_din);
        end
        @(posedge clk_sys);
        nvram_hps_ack <= 1'b0;
        osd_status    <= 1'b0;
        sd_buff       <= '0;
        @(negedge clk_sys);
        while (!nvram_allow_cpu_access) @(negedge clk_sys);
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        seed_value           = $urandom(60);
        cditop_reset         = 1'b1;
        osd_reset_req        = 1'b0;
        reset_on_nvram_mount = 1'b0;
        ioctl_download       = 1'b0;
        ioctl                = '0;
        core_sdram_req       = '0;
        sdram_busy           = 1'b0;
        nvram_media_change   = 1'b0;
        img_size             = '0;
        osd_status           = 1'b0;
        nvram_cpu_changed    = 1'b0;
        nvram_backup_data    = '0;
        nvram_hps_ack        = 1'b0;
        sd_buff              = '0;
        for (int i = 0; i < 8192; i++) begin
            nvram_mem[i] = fill_byte(i);
        end
        repeat (4) @(posedge clk_sys);
        cditop_reset <= 1'b0;
        reset_and_hold_test();
        rom_download_test();
        refresh_test();
        worm_test();
        restore_test();
        backup_test();
        @(posedge clk_sys);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verilog/cdi_consts.svh */
`ifndef CDI_CONSTS_SVH
`define CDI_CONSTS_SVH

// ==========================================================================
// SDRAM port
// ==========================================================================

`define CDI_SDRAM_ADDR_W    25
`define CDI_SDRAM_DATA_W    16

// Top word address bits of the boot ROM region
`define CDI_ROM_REGION_SEL  3'b001

// ==========================================================================
// Host download and block interface
// ==========================================================================

`define CDI_IOCTL_ADDR_W    25
`define CDI_IOCTL_INDEX_W   16

// Set for the slave WORM image, clear for the main boot ROM
`define CDI_WORM_INDEX_BIT  6

`define CDI_NVRAM_ADR_W     13   // 8 KB of NvRAM
`define CDI_SD_BUFF_ADDR_W  8
`define CDI_IMG_SIZE_W      64

`endif

/* verilog/cdi_host_bridge.sv */
`timescale 1ns/10ps

module cdi_host_bridge
    import cdi_pkg::*;
(
    input  logic        clk_sys,
    input  logic        cditop_reset,
    input  logic        osd_reset_req,
    input  logic        reset_on_nvram_mount,
    input  logic        ioctl_download,
    input  ioctl_beat_t ioctl,
    input  sdram_req_t  core_sdram_req,
    input  logic        sdram_busy,
    input  logic        nvram_media_change,
    input  img_size_t   img_size,
    input  logic        osd_status,
    input  logic        nvram_cpu_changed,
    input  byte_t       nvram_backup_data,
    input  logic        nvram_hps_ack,
    input  sd_buff_t    sd_buff,
    output sdram_req_t  sdram_req,
    output logic        core_hold,
    output logic        download_overflow,
    output worm_wr_t    worm_wr,
    output nvram_port_t nvram_port,
    output logic        nvram_allow_cpu_access,
    output logic        nvram_hps_rd,
    output logic        nvram_hps_wr,
    output sdram_word_t nvram_hps_din,
    output logic        led_user
);

    // Mount of an NvRAM image may hold the core
    logic nvram_mount_event;

    // ======================================================================
    // Core hold and SDRAM ownership
    // ======================================================================

    sdram_boot_arbiter u_sdram_boot_arbiter (
        .clk_sys              (clk_sys),
        .cditop_reset         (cditop_reset),
        .osd_reset_req        (osd_reset_req),
        .reset_on_nvram_mount (reset_on_nvram_mount),
        .nvram_mount_event    (nvram_mount_event),
        .ioctl_download       (ioctl_download),
        .ioctl                (ioctl),
        .core_sdram_req       (core_sdram_req),
        .sdram_busy           (sdram_busy),
        .sdram_req            (sdram_req),
        .core_hold            (core_hold),
        .download_overflow    (download_overflow)
    );

    // Slave WORM loading
    worm_byte_splitter u_worm_byte_splitter (
        .clk_sys      (clk_sys),
        .cditop_reset (cditop_reset),
        .ioctl        (ioctl),
        .worm_wr      (worm_wr)
    );

    // ======================================================================
    // NvRAM restore and backup
    // ======================================================================

    nvram_sync_fsm u_nvram_sync_fsm (
        .clk_sys                (clk_sys),
        .cditop_reset           (cditop_reset),
        .core_hold              (core_hold),
        .nvram_media_change     (nvram_media_change),
        .img_size               (img_size),
        .osd_status             (osd_status),
        .nvram_cpu_changed      (nvram_cpu_changed),
        .nvram_backup_data      (nvram_backup_data),
        .nvram_hps_ack          (nvram_hps_ack),
        .sd_buff                (sd_buff),
        .nvram_mount_event      (nvram_mount_event),
        .nvram_port             (nvram_port),
        .nvram_allow_cpu_access (nvram_allow_cpu_access),
        .nvram_hps_rd           (nvram_hps_rd),
        .nvram_hps_wr           (nvram_hps_wr),
        .nvram_hps_din          (nvram_hps_din),
        .backup_pending         (led_user)
    );

endmodule

/* verilog/cdi_pkg.sv */
`include "cdi_consts.svh"

package cdi_pkg;

    typedef logic [`CDI_SDRAM_ADDR_W-1:0]   sdram_addr_t;
    typedef logic [`CDI_SDRAM_DATA_W-1:0]   sdram_word_t;
    typedef logic [7:0]                     byte_t;
    typedef logic [`CDI_IOCTL_ADDR_W-1:0]   ioctl_addr_t;
    typedef logic [`CDI_IOCTL_INDEX_W-1:0]  ioctl_index_t;
    typedef logic [`CDI_NVRAM_ADR_W-1:0]    nvram_adr_t;
    typedef logic [`CDI_SD_BUFF_ADDR_W-1:0] sd_buff_addr_t;
    typedef logic [`CDI_IMG_SIZE_W-1:0]     img_size_t;

    // One request on the SDRAM controller port
    typedef struct packed {
        sdram_addr_t addr;
        sdram_word_t din;
        logic        rd;
        logic        wr;
        logic        word;
        logic        refresh;
        logic        burst;
    } sdram_req_t;

    // One download word from the host
    typedef struct packed {
        logic         wr;
        ioctl_addr_t  addr;
        ioctl_index_t index;
        sdram_word_t  data;
    } ioctl_beat_t;

    typedef struct packed {
        logic       wr;
        nvram_adr_t adr;
        byte_t      data;
    } worm_wr_t;

    // Byte access into the NvRAM of the core
    typedef struct packed {
        logic       write;
        nvram_adr_t adr;
        byte_t      data;
    } nvram_port_t;

    typedef struct packed {
        sd_buff_addr_t addr;
        sdram_word_t   data;
        logic          wr;
    } sd_buff_t;

    typedef enum logic [1:0] {
        OWNER_ROM_DOWNLOAD,
        OWNER_REFRESH,
        OWNER_IDLE
    } sdram_owner_e;

    typedef enum logic [3:0] {
        NVRAM_IDLE,
        NVRAM_WAIT_FOR_ACK,
        NVRAM_BACKUP0,
        NVRAM_BACKUP1,
        NVRAM_BACKUP2,
        NVRAM_BACKUP3,
        NVRAM_RESTORE0,
        NVRAM_RESTORE1,
        NVRAM_RESTORE2
    } nvram_state_e;

endpackage

/* verilog/nvram_sync_fsm.sv */
`timescale 1ns/10ps

module nvram_sync_fsm
    import cdi_pkg::*;
(
    input  logic        clk_sys,
    input  logic        cditop_reset,
    input  logic        core_hold,
    input  logic        nvram_media_change,
    input  img_size_t   img_size,
    input  logic        osd_status,
    input  logic        nvram_cpu_changed,
    input  byte_t       nvram_backup_data,
    input  logic        nvram_hps_ack,
    input  sd_buff_t    sd_buff,
    output logic        nvram_mount_event,
    output nvram_port_t nvram_port,
    output logic        nvram_allow_cpu_access,
    output logic        nvram_hps_rd,
    output logic        nvram_hps_wr,
    output sdram_word_t nvram_hps_din,
    output logic        backup_pending
);

    nvram_state_e  state;
    nvram_adr_t    adr;
    sdram_word_t   restore_word;
    sd_buff_addr_t buff_addr_q;
    logic          port_write;
    logic          img_mounted;
    logic          osd_q;
    logic          restore_start;
    logic          backup_start;

    // Pulses while the host reports a freshly mounted, non-empty image
    assign nvram_mount_event = nvram_media_change && (img_size != '0);

    assign restore_start = (state == NVRAM_IDLE) && nvram_mount_event;

    // Backup on OSD open, restore takes priority
    assign backup_start = (state == NVRAM_IDLE) && !nvram_mount_event &&
                          backup_pending && osd_status && !osd_q;

    // ======================================================================
    // Mount tracking and backup pending flag
    // ======================================================================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            img_mounted    <= 1'b0;
            osd_q          <= 1'b0;
            backup_pending <= 1'b0;
        end else begin
            osd_q <= osd_status;
            if (nvram_media_change) begin
                img_mounted <= (img_size != '0);
            end
            // A new change during a backup raises the flag again
            if (core_hold || backup_start) begin
                backup_pending <= 1'b0;
            end else if (nvram_cpu_changed && img_mounted) begin
                backup_pending <= 1'b1;
            end
        end
    end

    // ======================================================================
    // Restore and backup state machine
    // ======================================================================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            state                  <= NVRAM_IDLE;
            adr                    <= '0;
            port_write             <= 1'b0;
            nvram_allow_cpu_access <= 1'b1;
            nvram_hps_rd           <= 1'b0;
            nvram_hps_wr           <= 1'b0;
        end else begin
            port_write <= 1'b0;

            // Requests drop once the host has taken them
            if (nvram_hps_ack) begin
                nvram_hps_rd <= 1'b0;
                nvram_hps_wr <= 1'b0;
            end

            case (state)
                NVRAM_IDLE: begin
                    nvram_allow_cpu_access <= 1'b1;
                    adr                    <= '0;
                    if (restore_start) begin
                        nvram_hps_rd           <= 1'b1;
                        nvram_allow_cpu_access <= 1'b0;
                        state                  <= NVRAM_WAIT_FOR_ACK;
                    end else if (backup_start) begin
                        nvram_hps_wr           <= 1'b1;
                        nvram_allow_cpu_access <= 1'b0;
                        state                  <= NVRAM_WAIT_FOR_ACK;
                    end
                end
                NVRAM_WAIT_FOR_ACK: begin
                    if (nvram_hps_ack) begin
                        if (nvram_hps_rd) begin
                            state <= NVRAM_RESTORE0;
                        end
                        if (nvram_hps_wr) begin
                            state <= NVRAM_BACKUP0;
                        end
                    end
                end
                // Core data trails the address by one cycle
                NVRAM_BACKUP0: begin
                    adr   <= adr + 1'b1;
                    state <= NVRAM_BACKUP1;
                end
                NVRAM_BACKUP1: begin
                    adr   <= adr + 1'b1;
                    state <= NVRAM_BACKUP2;
                end
                NVRAM_BACKUP2: begin
                    state <= NVRAM_BACKUP3;
                end
                NVRAM_BACKUP3: begin
                    // Host stepped to the next buffer word
                    if (sd_buff.addr != buff_addr_q) begin
                        adr   <= adr + 1'b1;
                        state <= NVRAM_BACKUP1;
                    end
                    if (!nvram_hps_ack) begin
                        nvram_allow_cpu_access <= 1'b1;
                        state                  <= NVRAM_IDLE;
                    end
                end
                NVRAM_RESTORE0: begin
                    if (sd_buff.wr) begin
                        port_write <= 1'b1;
                        state      <= NVRAM_RESTORE1;
                    end
                    if (!nvram_hps_ack) begin
                        nvram_allow_cpu_access <= 1'b1;
                        state                  <= NVRAM_IDLE;
                    end
                end
                // Second byte of the word at the odd address
                NVRAM_RESTORE1: begin
                    port_write <= 1'b1;
                    adr        <= adr + 1'b1;
                    state      <= NVRAM_RESTORE2;
                end
                NVRAM_RESTORE2: begin
                    adr   <= adr + 1'b1;
                    state <= NVRAM_RESTORE0;
                end
                default: begin
                    state <= NVRAM_IDLE;
                end
            endcase
        end
    end

    // Data words of both transfer directions
    always_ff @(posedge clk_sys) begin
        buff_addr_q <= sd_buff.addr;
        if ((state == NVRAM_RESTORE0) && sd_buff.wr) begin
            restore_word <= sd_buff.data;
        end
        if (state == NVRAM_BACKUP1) begin
            nvram_hps_din[7:0] <= nvram_backup_data;
        end
        if (state == NVRAM_BACKUP2) begin
            nvram_hps_din[15:8] <= nvram_backup_data;
        end
    end

    assign nvram_port.write = port_write;
    assign nvram_port.adr   = adr;
    // Even address takes the low byte
    assign nvram_port.data  = adr[0] ? restore_word[15:8] : restore_word[7:0];

endmodule

/* verilog/sdram_boot_arbiter.sv */
`timescale 1ns/10ps

`include "cdi_consts.svh"

module sdram_boot_arbiter
    import cdi_pkg::*;
(
    input  logic        clk_sys,
    input  logic        cditop_reset,
    input  logic        osd_reset_req,
    input  logic        reset_on_nvram_mount,
    input  logic        nvram_mount_event,
    input  logic        ioctl_download,
    input  ioctl_beat_t ioctl,
    input  sdram_req_t  core_sdram_req,
    input  logic        sdram_busy,
    output sdram_req_t  sdram_req,
    output logic        core_hold,
    output logic        download_overflow
);

    logic         hold_request;
    logic         rom_beat;
    logic         rom_latch;
    logic         rom_done;
    logic         busy_q;
    ioctl_addr_t  rom_addr;
    sdram_word_t  rom_data;
    sdram_owner_e owner;
    sdram_owner_e owner_q;
    sdram_owner_e owner_next;
    sdram_req_t   boot_req;

    // ======================================================================
    // Core hold
    // ======================================================================

    assign hold_request = osd_reset_req || ioctl_download ||
                          (nvram_mount_event && reset_on_nvram_mount);

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            core_hold <= 1'b1;
        end else begin
            core_hold <= hold_request;
        end
    end

    // ======================================================================
    // ROM download latch
    // ======================================================================

    assign rom_beat = ioctl.wr && !ioctl.index[`CDI_WORM_INDEX_BIT];

    // Falling busy edge of a write issued by this block
    assign rom_done = (owner_q == OWNER_ROM_DOWNLOAD) && busy_q && !sdram_busy;

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            rom_latch         <= 1'b0;
            download_overflow <= 1'b0;
            owner_q           <= OWNER_IDLE;
            busy_q            <= 1'b0;
        end else begin
            busy_q  <= sdram_busy;
            owner_q <= owner;
            // Host sent a new word before the last one reached SDRAM
            if (rom_beat && rom_latch) begin
                download_overflow <= 1'b1;
            end
            if (rom_beat) begin
                rom_latch <= 1'b1;
            end else if (rom_done) begin
                rom_latch <= 1'b0;
            end
        end
    end

    // Word in flight stays stable until its write completes
    always_ff @(posedge clk_sys) begin
        if (rom_beat && !rom_latch) begin
            rom_addr <= ioctl.addr;
            rom_data <= ioctl.data;
        end
    end

    // ======================================================================
    // Owner selection and port mux
    // ======================================================================

    always_comb begin
        owner_next = OWNER_IDLE;
        if (core_hold) begin
            if (!rom_latch) begin
                owner_next = OWNER_REFRESH;
            end else if (!rom_done) begin
                owner_next = OWNER_ROM_DOWNLOAD;
            end
        end
        // The owner of a running access keeps the port
        owner = sdram_busy ? owner_q : owner_next;
    end

    always_comb begin
        boot_req      = '0;
        boot_req.addr = {`CDI_ROM_REGION_SEL, rom_addr[21:1], 1'b0};
        // Host words are little endian, the 68k wants big endian
        boot_req.din  = {rom_data[7:0], rom_data[15:8]};
        boot_req.word = 1'b1;
        case (owner)
            OWNER_ROM_DOWNLOAD: begin
                boot_req.wr = 1'b1;
            end
            OWNER_REFRESH: begin
                boot_req.rd      = 1'b1;
                boot_req.refresh = 1'b1;
            end
            default: begin
            end
        endcase
        if (sdram_busy) begin
            boot_req.rd = 1'b0;
            boot_req.wr = 1'b0;
        end
    end

    assign sdram_req = core_hold ? boot_req : core_sdram_req;

endmodule

/* verilog/worm_byte_splitter.sv */
`timescale 1ns/10ps

`include "cdi_consts.svh"

module worm_byte_splitter
    import cdi_pkg::*;
(
    input  logic        clk_sys,
    input  logic        cditop_reset,
    input  ioctl_beat_t ioctl,
    output worm_wr_t    worm_wr
);

    logic       worm_beat;
    logic       worm_beat_q;
    logic       wr_q;
    nvram_adr_t adr_q;
    byte_t      data_q;
    byte_t      second_byte;

    assign worm_beat = ioctl.wr && ioctl.index[`CDI_WORM_INDEX_BIT];

    // Two strobes per beat, one for each byte
    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            worm_beat_q <= 1'b0;
            wr_q        <= 1'b0;
        end else begin
            worm_beat_q <= worm_beat;
            wr_q        <= worm_beat || worm_beat_q;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (worm_beat) begin
            // Lower byte first
            adr_q       <= ioctl.addr[12:0];
            data_q      <= ioctl.data[7:0];
            second_byte <= ioctl.data[15:8];
        end else begin
            data_q   <= second_byte;
            adr_q[0] <= 1'b1;
        end
    end

    assign worm_wr.wr   = wr_q;
    assign worm_wr.adr  = adr_q;
    assign worm_wr.data = data_q;

endmodule
